/* y86Pkg.sv */
package y86Pkg;

    // ----------------------------------------------------------------------
    // architecture constants
    // ----------------------------------------------------------------------
    localparam int WORD_W = 64;                             // Y86-64 data word

    localparam logic [3:0] REG_NONE = 4'hF;                 // register id for no register

    localparam logic [WORD_W-1:0] STACK_STEP = 64'd8;       // one quad word on the stack

    // condition code bit positions inside the 3 bit flag vector
    localparam int ZF_BIT = 2;
    localparam int SF_BIT = 1;
    localparam int OF_BIT = 0;

    localparam logic [2:0] CC_RESET = 3'b100;               // zero flag set, sign and overflow clear

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        HALT   = 4'h0,
        NOP    = 4'h1,
        CMOVXX = 4'h2,                                      // rrmovq shares this code with ifun 0
        IRMOVQ = 4'h3,
        RMMOVQ = 4'h4,
        MRMOVQ = 4'h5,
        OPQ    = 4'h6,
        JXX    = 4'h7,
        CALL   = 4'h8,
        RET    = 4'h9,
        PUSHQ  = 4'hA,
        POPQ   = 4'hB
    } icodeE;

    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        XOR = 4'h3
    } aluFunE;

    typedef enum logic [3:0] {
        YES = 4'h0,
        LE  = 4'h1,
        L   = 4'h2,
        E   = 4'h3,
        NE  = 4'h4,
        GE  = 4'h5,
        G   = 4'h6
    } condE;

    // status travelling with each instruction through the pipe
    typedef enum logic [2:0] {
        BUBBLE = 3'd0,
        OK     = 3'd1,
        STALL  = 3'd4
    } statE;

endpackage

/* executeRegister.sv */
`timescale 1ns/1ps

module executeRegister (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         stall_i,
    input  logic                         bubble_i,
    input  y86Pkg::icodeE                icode_i,
    input  logic [3:0]                   ifun_i,
    input  y86Pkg::statE                 stat_i,
    input  logic [y86Pkg::WORD_W-1:0]    valA_i,
    input  logic [y86Pkg::WORD_W-1:0]    valB_i,
    input  logic [y86Pkg::WORD_W-1:0]    valC_i,
    input  logic [3:0]                   dstE_i,
    input  logic [3:0]                   dstM_i,
    output y86Pkg::icodeE                icode_o,
    output logic [3:0]                   ifun_o,
    output y86Pkg::statE                 stat_o,
    output logic [y86Pkg::WORD_W-1:0]    valA_o,
    output logic [y86Pkg::WORD_W-1:0]    valB_o,
    output logic [y86Pkg::WORD_W-1:0]    valC_o,
    output logic [3:0]                   dstE_o,
    output logic [3:0]                   dstM_o
);

    logic loadBubble;

    // stall beats bubble so a held instruction is never thrown away
    assign loadBubble = !rst_n_i || (bubble_i && !stall_i);

    always_ff @(posedge clk_i) begin
        if (loadBubble) begin
            icode_o <= y86Pkg::NOP;
            ifun_o  <= 4'h0;
            stat_o  <= y86Pkg::BUBBLE;
            valA_o  <= '0;
            valB_o  <= '0;
            valC_o  <= '0;
            dstE_o  <= y86Pkg::REG_NONE;
            dstM_o  <= y86Pkg::REG_NONE;
        end else if (!stall_i) begin
            icode_o <= icode_i;
            ifun_o  <= ifun_i;
            stat_o  <= stat_i;
            valA_o  <= valA_i;
            valB_o  <= valB_i;
            valC_o  <= valC_i;
            dstE_o  <= dstE_i;
            dstM_o  <= dstM_i;
        end                                             // otherwise hold the stalled instruction
    end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  y86Pkg::icodeE                icode_i,
    input  logic [3:0]                   ifun_i,
    input  logic [y86Pkg::WORD_W-1:0]    valA_i,
    input  logic [y86Pkg::WORD_W-1:0]    valB_i,
    input  logic [y86Pkg::WORD_W-1:0]    valC_i,
    output logic [y86Pkg::WORD_W-1:0]    valE_o,
    output logic [2:0]                   newCc_o,
    output logic                         setCc_o
);

    localparam int MSB = y86Pkg::WORD_W - 1;

    logic [y86Pkg::WORD_W-1:0] aluA;
    logic [y86Pkg::WORD_W-1:0] aluB;
    y86Pkg::aluFunE            aluFun;

    // ----------------------------------------------------------------------
    // operand selection
    // ----------------------------------------------------------------------
    always_comb begin
        case (icode_i)
            y86Pkg::CMOVXX: begin
                aluA = valA_i;
                aluB = '0;
            end
            y86Pkg::IRMOVQ: begin
                aluA = valC_i;
                aluB = '0;
            end
            y86Pkg::RMMOVQ, y86Pkg::MRMOVQ: begin
                aluA = valC_i;                          // displacement plus base register
                aluB = valB_i;
            end
            y86Pkg::OPQ: begin
                aluA = valA_i;
                aluB = valB_i;
            end
            y86Pkg::CALL, y86Pkg::PUSHQ: begin
                aluA = -y86Pkg::STACK_STEP;             // stack grows toward lower addresses
                aluB = valB_i;
            end
            y86Pkg::RET, y86Pkg::POPQ: begin
                aluA = y86Pkg::STACK_STEP;
                aluB = valB_i;
            end
            default: begin
                aluA = '0;
                aluB = '0;
            end
        endcase
    end

    assign aluFun = (icode_i == y86Pkg::OPQ) ? y86Pkg::aluFunE'(ifun_i) : y86Pkg::ADD;

    // ----------------------------------------------------------------------
    // ALU and new flags
    // ----------------------------------------------------------------------
    always_comb begin
        case (aluFun)
            y86Pkg::ADD: valE_o = aluB + aluA;
            y86Pkg::SUB: valE_o = aluB - aluA;
            y86Pkg::AND: valE_o = aluB & aluA;
            y86Pkg::XOR: valE_o = aluB ^ aluA;
            default:     valE_o = '0;
        endcase
    end

    always_comb begin
        newCc_o[y86Pkg::ZF_BIT] = (valE_o == '0);
        newCc_o[y86Pkg::SF_BIT] = valE_o[MSB];
        case (aluFun)
            y86Pkg::ADD: newCc_o[y86Pkg::OF_BIT] = (aluA[MSB] == aluB[MSB]) &&
                                                   (valE_o[MSB] != aluB[MSB]);
            y86Pkg::SUB: newCc_o[y86Pkg::OF_BIT] = (aluA[MSB] != aluB[MSB]) &&
                                                   (valE_o[MSB] != aluB[MSB]);
            default:     newCc_o[y86Pkg::OF_BIT] = 1'b0;   // logic ops never overflow
        endcase
    end

    assign setCc_o = (icode_i == y86Pkg::OPQ);

endmodule

/* condUnit.sv */
`timescale 1ns/1ps

module condUnit (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          stall_i,
    input  logic          setCc_i,
    input  logic [2:0]    newCc_i,
    input  y86Pkg::icodeE icode_i,
    input  logic [3:0]    ifun_i,
    output logic          cnd_o
);

    logic [2:0] cc;
    logic       zf;
    logic       sf;
    logic       of;
    logic       condMet;
    logic       usesCond;

    // flags change on the edge that hands the OPq on to the memory stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cc <= y86Pkg::CC_RESET;
        end else if (setCc_i && !stall_i) begin
            cc <= newCc_i;
        end
    end

    assign zf = cc[y86Pkg::ZF_BIT];
    assign sf = cc[y86Pkg::SF_BIT];
    assign of = cc[y86Pkg::OF_BIT];

    always_comb begin
        case (y86Pkg::condE'(ifun_i))
            y86Pkg::YES: condMet = 1'b1;
            y86Pkg::LE:  condMet = (sf ^ of) | zf;
            y86Pkg::L:   condMet = sf ^ of;
            y86Pkg::E:   condMet = zf;
            y86Pkg::NE:  condMet = !zf;
            y86Pkg::GE:  condMet = !(sf ^ of);
            y86Pkg::G:   condMet = !(sf ^ of) && !zf;
            default:     condMet = 1'b0;                // undefined condition codes never fire
        endcase
    end

    assign usesCond = (icode_i == y86Pkg::JXX) || (icode_i == y86Pkg::CMOVXX);
    assign cnd_o    = usesCond && condMet;

endmodule

/* memoryRegister.sv */
`timescale 1ns/1ps

module memoryRegister (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         stall_i,
    input  y86Pkg::icodeE                icode_i,
    input  y86Pkg::statE                 stat_i,
    input  logic [y86Pkg::WORD_W-1:0]    valE_i,
    input  logic [y86Pkg::WORD_W-1:0]    valA_i,
    input  logic [3:0]                   dstE_i,
    input  logic [3:0]                   dstM_i,
    input  logic                         cnd_i,
    output y86Pkg::icodeE                icode_o,
    output y86Pkg::statE                 stat_o,
    output logic [y86Pkg::WORD_W-1:0]    valE_o,
    output logic [y86Pkg::WORD_W-1:0]    valA_o,
    output logic [3:0]                   dstE_o,
    output logic [3:0]                   dstM_o,
    output logic                         cnd_o
);

    logic [3:0] dstESel;

    // a conditional move that fails writes nothing back
    assign dstESel = (icode_i == y86Pkg::CMOVXX && !cnd_i) ? y86Pkg::REG_NONE : dstE_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || stall_i) begin                  // the held E instruction must not repeat
            icode_o <= y86Pkg::NOP;
            stat_o  <= y86Pkg::BUBBLE;
            valE_o  <= '0;
            valA_o  <= '0;
            dstE_o  <= y86Pkg::REG_NONE;
            dstM_o  <= y86Pkg::REG_NONE;
            cnd_o   <= 1'b0;
        end else begin
            icode_o <= icode_i;
            stat_o  <= stat_i;
            valE_o  <= valE_i;
            valA_o  <= valA_i;
            dstE_o  <= dstESel;
            dstM_o  <= dstM_i;
            cnd_o   <= cnd_i;
        end
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         stall_i,
    input  logic                         bubble_i,
    input  y86Pkg::icodeE                icode_i,
    input  logic [3:0]                   ifun_i,
    input  y86Pkg::statE                 stat_i,
    input  logic [y86Pkg::WORD_W-1:0]    valA_i,
    input  logic [y86Pkg::WORD_W-1:0]    valB_i,
    input  logic [y86Pkg::WORD_W-1:0]    valC_i,
    input  logic [3:0]                   dstE_i,
    input  logic [3:0]                   dstM_i,
    input  logic [3:0]                   srcA_i,     // forwarding sources are not needed here
    input  logic [3:0]                   srcB_i,
    output y86Pkg::icodeE                icode_o,
    output y86Pkg::statE                 stat_o,
    output logic [y86Pkg::WORD_W-1:0]    valE_o,
    output logic [y86Pkg::WORD_W-1:0]    valA_o,
    output logic [3:0]                   dstE_o,
    output logic [3:0]                   dstM_o,
    output logic                         cnd_o
);

    // ----------------------------------------------------------------------
    // E stage fields and execute results
    // ----------------------------------------------------------------------
    y86Pkg::icodeE             eIcode;
    logic [3:0]                eIfun;
    y86Pkg::statE              eStat;
    logic [y86Pkg::WORD_W-1:0] eValA;
    logic [y86Pkg::WORD_W-1:0] eValB;
    logic [y86Pkg::WORD_W-1:0] eValC;
    logic [3:0]                eDstE;
    logic [3:0]                eDstM;
    logic [y86Pkg::WORD_W-1:0] aluValE;
    logic [2:0]                aluNewCc;
    logic                      setCc;
    logic                      eCnd;

    executeRegister u_executeRegister (
        .clk_i   (clk_i),   .rst_n_i (rst_n_i), .stall_i (stall_i), .bubble_i (bubble_i),
        .icode_i (icode_i), .ifun_i  (ifun_i),  .stat_i  (stat_i),
        .valA_i  (valA_i),  .valB_i  (valB_i),  .valC_i  (valC_i),
        .dstE_i  (dstE_i),  .dstM_i  (dstM_i),
        .icode_o (eIcode),  .ifun_o  (eIfun),   .stat_o  (eStat),
        .valA_o  (eValA),   .valB_o  (eValB),   .valC_o  (eValC),
        .dstE_o  (eDstE),   .dstM_o  (eDstM)
    );

    aluUnit u_aluUnit (
        .icode_i (eIcode), .ifun_i (eIfun),
        .valA_i  (eValA),  .valB_i (eValB),  .valC_i (eValC),
        .valE_o  (aluValE), .newCc_o (aluNewCc), .setCc_o (setCc)
    );

    condUnit u_condUnit (
        .clk_i   (clk_i),  .rst_n_i (rst_n_i), .stall_i (stall_i),
        .setCc_i (setCc),  .newCc_i (aluNewCc),
        .icode_i (eIcode), .ifun_i  (eIfun),   .cnd_o   (eCnd)
    );

    memoryRegister u_memoryRegister (
        .clk_i   (clk_i),   .rst_n_i (rst_n_i), .stall_i (stall_i),
        .icode_i (eIcode),  .stat_i  (eStat),   .valE_i  (aluValE), .valA_i (eValA),
        .dstE_i  (eDstE),   .dstM_i  (eDstM),   .cnd_i   (eCnd),
        .icode_o (icode_o), .stat_o  (stat_o),  .valE_o  (valE_o),  .valA_o (valA_o),
        .dstE_o  (dstE_o),  .dstM_o  (dstM_o),  .cnd_o   (cnd_o)
    );

endmodule

/* executeStage_props.sv */
`timescale 1ns/1ps

module executeStageProps (
    input logic          clk_i,
    input logic          rst_n_i,
    input logic          stall_i,
    input y86Pkg::icodeE icode_o,
    input y86Pkg::statE  stat_o,
    input logic          cnd_o
);

    // the first two cycles after reset still carry the reset bubble
    property resetBubble;
        @(posedge clk_i) $rose(rst_n_i) |-> stat_o == y86Pkg::BUBBLE ##1 stat_o == y86Pkg::BUBBLE;
    endproperty

    property cndOnlyForBranch;
        @(posedge clk_i) disable iff (!rst_n_i)
            cnd_o |-> (icode_o == y86Pkg::JXX || icode_o == y86Pkg::CMOVXX);
    endproperty

    property stallSendsBubble;
        @(posedge clk_i) disable iff (!rst_n_i) stall_i |=> stat_o == y86Pkg::BUBBLE;
    endproperty

    aResetBubble: assert property (resetBubble) else $error("no bubble after reset");
    aCnd:         assert property (cndOnlyForBranch) else $error("cnd_o set for a non branch");
    aStall:       assert property (stallSendsBubble) else $error("stall did not send a bubble");

endmodule

bind executeStage executeStageProps u_executeStageProps (.*);

/* executeStage_tb.sv */
`timescale 1ns/1ps

module executeStage_tb;

    localparam int CYCLE_LIMIT = 6 + (3 + 28 + 6 + 4 + 8 + 300) + 6 * 2 + 50;

    logic clk_i = 1'b0;
    logic rst_n_i, stall_i, bubble_i;
    y86Pkg::icodeE icode_i;
    y86Pkg::statE  stat_i;
    logic [3:0]  ifun_i, dstE_i, dstM_i, srcA_i, srcB_i;
    logic [63:0] valA_i, valB_i, valC_i;
    y86Pkg::icodeE icode_o;
    y86Pkg::statE  stat_o;
    logic [63:0] valE_o, valA_o;
    logic [3:0]  dstE_o, dstM_o;
    logic        cnd_o;

    // model state for both pipeline registers and the flags
    logic [3:0]  eIc, eFn, eDe, eDm, mIc, mDe, mDm;
    logic [2:0]  eSt, mSt, cc;
    logic [63:0] eA, eB, eC, mE, mA;
    logic        mCnd;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    executeStage u_executeStage (.*);

    initial begin
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [66:0] aluModel(logic [3:0] ic, logic [3:0] fn,
                                             logic [63:0] a, logic [63:0] b, logic [63:0] c);
        logic [63:0] x, y, r;
        logic [64:0] wide;
        logic [3:0]  f;
        logic        ovf;
        {x, y} = '0;
        case (ic)
            4'h2: x = a;
            4'h3: x = c;
            4'h4, 4'h5: {x, y} = {c, b};
            4'h6: {x, y} = {a, b};
            4'h8, 4'hA: {x, y} = {64'hFFFF_FFFF_FFFF_FFF8, b};
            4'h9, 4'hB: {x, y} = {64'd8, b};
            default: ;
        endcase
        f = (ic == 4'h6) ? fn : 4'h0;
        case (f)
            4'h0: wide = {y[63], y} + {x[63], x};
            4'h1: wide = {y[63], y} - {x[63], x};
            4'h2: wide = {1'b0, y & x};
            4'h3: wide = {1'b0, y ^ x};
            default: wide = '0;
        endcase
        r   = wide[63:0];
        ovf = (f < 4'h2) && (wide[64] != wide[63]);     // exact signed sum no longer fits
        return {r, r == 0, r[63], ovf};
    endfunction

    function automatic logic condModel(logic [3:0] ic, logic [3:0] fn, logic [2:0] f);
        logic lt;
        logic res;
        lt = f[1] ^ f[0];
        case (fn)
            4'h0: res = 1;
            4'h1: res = lt | f[2];
            4'h2: res = lt;
            4'h3: res = f[2];
            4'h4: res = !f[2];
            4'h5: res = !lt;
            4'h6: res = !lt && !f[2];
            default: res = 0;
        endcase
        return res && (ic == 4'h7 || ic == 4'h2);
    endfunction

    always @(posedge clk_i) begin
        logic [66:0] alu;
        logic        cnd;
        alu = aluModel(eIc, eFn, eA, eB, eC);
        cnd = condModel(eIc, eFn, cc);
        if (!rst_n_i || stall_i) begin
            {mIc, mSt, mE, mA, mDe, mDm, mCnd} = {4'h1, 3'd0, 128'd0, 8'hFF, 1'b0};
        end else begin
            {mIc, mSt, mE, mA, mDm, mCnd} = {eIc, eSt, alu[66:3], eA, eDm, cnd};
            mDe = (eIc == 4'h2 && !cnd) ? 4'hF : eDe;
        end
        if (!rst_n_i) cc = 3'b100;
        else if (eIc == 4'h6 && !stall_i) cc = alu[2:0];
        if (!rst_n_i || (bubble_i && !stall_i)) begin
            {eIc, eFn, eSt, eA, eB, eC, eDe, eDm} = {4'h1, 4'h0, 3'd0, 192'd0, 8'hFF};
        end else if (!stall_i) begin
            {eIc, eFn, eSt, eA, eB, eC} = {icode_i, ifun_i, stat_i, valA_i, valB_i, valC_i};
            {eDe, eDm} = {dstE_i, dstM_i};
        end
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish");
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkVal(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // checks the outputs of the last edge, then drives the next inputs
    task automatic drive(logic [3:0] ic, logic [3:0] fn, logic [63:0] a, logic [63:0] b,
                         logic [63:0] c, logic [3:0] de, logic st, logic bu);
        @(negedge clk_i);
        checkVal("icode_o", icode_o, mIc);
        checkVal("stat_o", stat_o, mSt);
        checkVal("valE_o", valE_o, mE);
        checkVal("valA_o", valA_o, mA);
        checkVal("dstE_o", dstE_o, mDe);
        checkVal("dstM_o", dstM_o, mDm);
        checkVal("cnd_o", cnd_o, mCnd);
        icode_i = y86Pkg::icodeE'(ic);
        {ifun_i, valA_i, valB_i, valC_i, dstE_i, stall_i, bubble_i} = {fn, a, b, c, de, st, bu};
        dstM_i = 4'($urandom);
        srcA_i = 4'($urandom);
        srcB_i = 4'($urandom);
    endtask

    function automatic logic [63:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    task automatic finishTest(string name, int errBefore);
        drive(4'h1, 0, 0, 0, 0, 4'hF, 0, 0);
        drive(4'h1, 0, 0, 0, 0, 4'hF, 0, 0);
        $display("test %-12s done, %0d errors", name, errors - errBefore);
    endtask

    initial begin
        int e;
        logic [63:0] a, b;
        void'($urandom(32'h3f43_7555));
        {rst_n_i, stall_i, bubble_i, ifun_i, dstE_i, dstM_i, srcA_i, srcB_i} = '0;
        {valA_i, valB_i, valC_i} = '0;
        icode_i = y86Pkg::NOP;
        stat_i  = y86Pkg::OK;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i) rst_n_i = 1'b1;

        e = errors;                                 // reset state, then JXX LE sees ZF
        drive(4'h7, 4'h1, rnd64(), 0, rnd64(), 4'hF, 0, 0);
        drive(4'h1, 0, 0, 0, 0, 4'hF, 0, 0);
        drive(4'h1, 0, 0, 0, 0, 4'hF, 0, 0);
        finishTest("reset", e);

        e = errors;
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 7; k++) begin
                a = (k < 3) ? 64'h7FFF_FFFF_FFFF_FFFF - r : rnd64();
                b = (k < 3) ? {1'b1 ^ k[0], 63'(k)} : rnd64();
                drive(4'h6, 4'($urandom_range(3)), a, b, 0, 4'($urandom), 0, 0);
                drive(4'h7, 4'(k), 0, 0, rnd64(), 4'hF, 0, 0);
            end
        end
        finishTest("opq_jxx", e);

        e = errors;
        drive(4'h3, 0, rnd64(), rnd64(), rnd64(), 4'h2, 0, 0);
        drive(4'h4, 0, rnd64(), rnd64(), rnd64(), 4'hF, 0, 0);
        drive(4'h5, 0, rnd64(), rnd64(), rnd64(), 4'hF, 0, 0);
        drive(4'h8, 0, rnd64(), rnd64(), rnd64(), 4'h4, 0, 0);
        drive(4'h9, 0, rnd64(), rnd64(), rnd64(), 4'h4, 0, 0);
        drive(4'hA, 0, rnd64(), rnd64(), rnd64(), 4'h4, 0, 0);
        finishTest("address", e);

        e = errors;
        a = rnd64();
        drive(4'h6, 4'h1, a, a, 0, 4'h1, 0, 0);     // equal operands set ZF
        drive(4'h2, 4'h3, rnd64(), 0, 0, 4'h3, 0, 0);
        drive(4'h2, 4'h4, rnd64(), 0, 0, 4'h4, 0, 0);
        drive(4'h2, 4'h6, rnd64(), 0, 0, 4'h5, 0, 0);
        finishTest("cmov", e);

        e = errors;
        drive(4'h6, 4'h0, rnd64(), rnd64(), 0, 4'h1, 0, 1);
        drive(4'h7, 4'h3, 0, 0, rnd64(), 4'hF, 0, 0);
        drive(4'h6, 4'h1, rnd64(), rnd64(), 0, 4'h2, 0, 0);
        drive(4'h3, 0, 0, 0, rnd64(), 4'h5, 1, 0);
        drive(4'h3, 0, 0, 0, rnd64(), 4'h5, 1, 1);
        drive(4'h7, 4'h2, 0, 0, rnd64(), 4'hF, 0, 0);
        drive(4'h7, 4'h5, 0, 0, rnd64(), 4'hF, 0, 0);
        drive(4'h1, 0, 0, 0, 0, 4'hF, 0, 0);
        finishTest("stall_bubble", e);

        e = errors;
        repeat (300) begin
            logic [3:0] ic;
            ic = 4'($urandom_range(11));
            drive(ic, (ic == 4'h6) ? 4'($urandom_range(3)) : 4'($urandom_range(6)),
                  rnd64(), rnd64(), rnd64(), 4'($urandom), $urandom_range(7) == 0,
                  $urandom_range(7) == 0);
        end
        finishTest("random_mix", e);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
y86Pkg.sv
executeRegister.sv
aluUnit.sv
condUnit.sv
memoryRegister.sv
executeStage.sv
executeStage_props.sv
executeStage_tb.sv
